//--- bench/spi_periph_model.sv
/*
  Behavioral Mode 0 SPI peripheral for the testbench. Records COPI bytes of the
  TX phase, answers with counting bytes on CIPO and counts stray SCK edges.
*/
module spi_periph_model (
  input  logic i_sck,
  input  logic i_csn,
  input  logic i_copi,
  output logic o_cipo
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned tx_bits;         // Rises that carry COPI payload
  int unsigned rx_first;        // Rise index of the first RX bit
  int unsigned rx_last;         // One past the last RX bit
  logic [7:0]  first_resp;
  bit          armed = 1'b0;    // Set once a frame is configured
  int unsigned rise_cnt;
  int unsigned stray_edges;     // SCK edges with csn not low
  logic [7:0]  copi_sr;
  logic [7:0]  copi_bytes [$];  // Captured TX bytes, in bus order
  logic        cipo_q = 1'b0;

  assign o_cipo = cipo_q;

  // Frame setup, called before each go
  task automatic configure(input int tx_len, input int wait_cyc, input int rx_len,
                           input logic [7:0] first);
    tx_bits     = 8 * tx_len;
    rx_first    = tx_bits + wait_cyc;
    rx_last     = rx_first + 8 * rx_len;
    first_resp  = first;
    rise_cnt    = 0;
    stray_edges = 0;
    copi_bytes.delete();
    armed       = 1'b1;
  endtask

  // Response bit due at rise idx, byte k of the answer is first_resp + k
  function automatic logic resp_bit(input int unsigned idx);
    int unsigned rel;
    logic [7:0]  b;
    if (idx < rx_first || idx >= rx_last)
      return 1'b0;
    rel = idx - rx_first;
    b   = first_resp + 8'(rel / 8);
    return b[7 - (rel % 8)];  // MSB first
  endfunction

  ////////////////////////////////////////////////////////////
  // Bus side
  ////////////////////////////////////////////////////////////
  always @(posedge i_sck) begin
    if (armed && i_csn === 1'b0) begin
      if (rise_cnt < tx_bits) begin
        copi_sr = {copi_sr[6:0], i_copi};
        if (rise_cnt % 8 == 7)
          copi_bytes.push_back(copi_sr);
      end
      rise_cnt++;
    end
  end

  // Next CIPO bit leaves on csn fall and after every SCK fall
  always @(negedge i_csn or negedge i_sck) begin
    if (armed && i_csn === 1'b0)
      cipo_q <= resp_bit(rise_cnt);
  end

  always @(i_sck) begin
    if (armed && i_csn !== 1'b0)
      stray_edges++;  // SCK moved outside chip select
  end

endmodule : spi_periph_model

//--- bench/tb_spi_solo.sv
/*
  Testbench of the SPI master. Runs a table of frames against a peripheral
  model and checks bus activity, FIFO handshakes and RX data.
*/
module tb_spi_solo
  import spi_solo_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_ROWS = 5;

  typedef struct packed {
    tx_len_t    tx_len;
    wait_cyc_t  wait_cyc;
    rx_len_t    rx_len;
    logic [4:0] n_enq;       // Bytes written before the go
    byte_t      first_resp;  // Peripheral answer starts here
    logic       dequeue;     // Drain the RX FIFO after the frame
  } row_t;

  row_t  rows [N_ROWS];
  string row_name [N_ROWS];
  string test_name = "setup";

  logic clk, srst, go_stand, tx_enqueue, rx_dequeue, cipo;
  logic spi_idle, tx_ready, rx_valid, sck, csn, copi;
  tx_len_t   tx_len;
  wait_cyc_t wait_cyc;
  rx_len_t   rx_len;
  byte_t     tx_data, rx_data;

  int    seed = 55352;
  int    err_cnt = 0;
  int    chk_cnt = 0;
  int    cycle_cnt = 0;
  int    cycle_limit = 0;
  byte_t tx_exp_q [$];  // Expected TX FIFO contents
  byte_t rx_exp_q [$];  // Expected RX FIFO contents

  spi_solo i_spi_solo (
    .i_ext_spi_clk_x (clk), .i_srst (srst), .i_go_stand (go_stand),
    .i_tx_len (tx_len), .i_wait_cyc (wait_cyc), .i_rx_len (rx_len),
    .o_spi_idle (spi_idle), .i_tx_data (tx_data), .i_tx_enqueue (tx_enqueue),
    .o_tx_ready (tx_ready), .o_rx_data (rx_data), .o_rx_valid (rx_valid),
    .i_rx_dequeue (rx_dequeue), .o_sck (sck), .o_csn (csn), .o_copi (copi),
    .i_cipo (cipo)
  );

  spi_periph_model u_periph (.i_sck (sck), .i_csn (csn), .i_copi (copi), .o_cipo (cipo));

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  // Watchdog, limit comes from the table
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      $display("Timeout in %s after %0d cycles, the frame never completed",
               test_name, cycle_cnt);
      $display("Checks: %0d  errors: %0d  timeouts: 1", chk_cnt, err_cnt);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////
  task automatic expect_eq(input string what, input logic [31:0] exp, input logic [31:0] got);
    chk_cnt++;
    assert (got == exp)
      else begin
        err_cnt++;
        $display("ERR %s %s: expected 0x%0h actual 0x%0h", test_name, what, exp, got);
      end
  endtask

  task automatic expect_true(input logic cond, input string msg);
    chk_cnt++;
    assert (cond)
      else begin
        err_cnt++;
        $display("%s: %s", test_name, msg);
      end
  endtask

  task automatic add_row(input int idx, input string name, input int tx, input int wt,
                         input int rx, input int n_enq, input int first, input bit deq);
    row_name[idx]        = name;
    rows[idx].tx_len     = tx_len_t'(tx);
    rows[idx].wait_cyc   = wait_cyc_t'(wt);
    rows[idx].rx_len     = rx_len_t'(rx);
    rows[idx].n_enq      = 5'(n_enq);
    rows[idx].first_resp = byte_t'(first);
    rows[idx].dequeue    = deq;
  endtask

  // Frame bit-times plus slack, in clocks
  function automatic int calc_limit();
    int total;
    total = 200;
    foreach (rows[r])
      total += (4 * T_GUARD + 8 * (int'(rows[r].tx_len) + int'(rows[r].rx_len)) +
                int'(rows[r].wait_cyc) + 4) * SCK_RATIO;
    return total;
  endfunction

  ////////////////////////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////////////////////////
  task automatic enqueue_bytes(input int n);
    byte_t b;
    for (int k = 0; k < n; k++) begin
      b = byte_t'($random(seed));
      @(posedge clk);
      #1;
      tx_data    = b;
      tx_enqueue = 1'b1;
      @(negedge clk);
      expect_eq($sformatf("tx_ready_byte%0d", k), tx_exp_q.size() < FIFO_DEPTH, tx_ready);
      if (tx_exp_q.size() < FIFO_DEPTH)
        tx_exp_q.push_back(b);  // Full FIFO drops the write
    end
    @(posedge clk);
    #1 tx_enqueue = 1'b0;
  endtask

  task automatic issue_go(input tx_len_t tx, input wait_cyc_t wt, input rx_len_t rx);
    @(posedge clk);
    #1;
    go_stand = 1'b1;
    tx_len   = tx;
    wait_cyc = wt;
    rx_len   = rx;
    @(negedge clk);
  endtask

  task automatic drain_rx;
    int n;
    n = rx_exp_q.size();
    for (int k = 0; k < n; k++) begin
      @(posedge clk);
      #1 rx_dequeue = 1'b1;
      @(negedge clk);
      expect_true(rx_valid === 1'b1, "o_rx_valid low while RX bytes were still expected");
      expect_eq($sformatf("rx_byte%0d", k), rx_exp_q[k], rx_data);
    end
    @(posedge clk);
    #1 rx_dequeue = 1'b0;
    @(negedge clk);
    expect_eq("rx_valid_after_drain", 0, rx_valid);
    rx_exp_q.delete();
  endtask

  task automatic run_row(input int r);
    row_t  row;
    int    low_cycles;
    byte_t exp_b;
    row        = rows[r];
    test_name  = row_name[r];
    low_cycles = 0;
    enqueue_bytes(row.n_enq);
    u_periph.configure(row.tx_len, row.wait_cyc, row.rx_len, row.first_resp);
    issue_go(row.tx_len, row.wait_cyc, row.rx_len);
    expect_true(spi_idle === 1'b1, "bus busy when the command was issued");
    @(posedge clk);
    #1 go_stand = 1'b0;
    @(negedge clk);
    expect_true(spi_idle === 1'b0, "o_spi_idle stayed high after the command was taken");
    // A go in mid frame must be ignored
    repeat (3 * SCK_RATIO) @(posedge clk);
    issue_go(4'hF, 2'd3, 4'hF);
    @(posedge clk);
    #1 go_stand = 1'b0;
    while (spi_idle !== 1'b1) @(negedge clk);
    repeat (2 * SCK_RATIO) begin
      @(negedge clk);
      if (spi_idle !== 1'b1)
        low_cycles++;  // Would mean a second frame started
    end
    expect_eq("idle_low_after_frame", 0, low_cycles);
    expect_eq("sck_rises", 8 * row.tx_len + row.wait_cyc + 8 * row.rx_len, u_periph.rise_cnt);
    expect_eq("sck_edges_csn_high", 0, u_periph.stray_edges);
    expect_eq("copi_byte_count", row.tx_len, u_periph.copi_bytes.size());
    for (int k = 0; k < row.tx_len; k++) begin
      exp_b = (tx_exp_q.size() > 0) ? tx_exp_q.pop_front() : 8'h00;  // Underflow sends zero
      if (k < u_periph.copi_bytes.size())
        expect_eq($sformatf("copi_byte%0d", k), exp_b, u_periph.copi_bytes[k]);
    end
    for (int k = 0; k < row.rx_len; k++)
      if (rx_exp_q.size() < FIFO_DEPTH)
        rx_exp_q.push_back(row.first_resp + 8'(k));
    if (row.dequeue)
      drain_rx();
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    srst       = 1'b1;
    go_stand   = 1'b0;
    tx_len     = '0;
    wait_cyc   = '0;
    rx_len     = '0;
    tx_data    = '0;
    tx_enqueue = 1'b0;
    rx_dequeue = 1'b0;
    //      name               tx wt rx enq first  deq
    add_row(0, "write_only",      3, 0, 0,  3, 8'h00, 1'b1);
    add_row(1, "write_wait_read", 2, 2, 3,  2, 8'hA5, 1'b1);
    add_row(2, "tx_underflow",    2, 0, 1,  1, 8'h3C, 1'b1);
    add_row(3, "fifo_overfill",  15, 1, 15, 18, 8'h10, 1'b0);
    add_row(4, "rx_overflow",     1, 0, 3,  0, 8'hF0, 1'b1);
    cycle_limit = calc_limit();
    repeat (4) @(posedge clk);
    #1 srst = 1'b0;
    test_name = "reset";
    @(negedge clk);
    expect_eq("csn", 1, csn);
    expect_eq("sck", 0, sck);
    expect_eq("copi", 0, copi);
    expect_eq("spi_idle", 1, spi_idle);
    expect_eq("tx_ready", 1, tx_ready);
    expect_eq("rx_valid", 0, rx_valid);
    for (int r = 0; r < N_ROWS; r++)
      run_row(r);
    $display("Checks: %0d  errors: %0d  timeouts: 0", chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule : tb_spi_solo

//--- hdl/byte_fifo.sv
/*
  Synchronous byte FIFO with first-word-fall-through output. The head entry is
  always on o_rd_data, a write shows there one cycle later.
*/
module byte_fifo
  import spi_solo_pkg::*;
(
  input  logic  i_ext_spi_clk_x,
  input  logic  i_srst,
  // Write side
  input  byte_t i_wr_data,
  input  logic  i_wr_en,
  output logic  o_full,
  // Read side
  output byte_t o_rd_data,
  input  logic  i_rd_en,
  output logic  o_empty
);

  byte_t     mem [FIFO_DEPTH];  // Storage array
  fifo_ptr_t wr_ptr;
  fifo_ptr_t rd_ptr;
  logic      do_wr;
  logic      do_rd;

  // Same address with differing wrap bits means full
  assign o_full  = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                   (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);
  assign o_empty = (wr_ptr == rd_ptr);

  assign do_wr = i_wr_en && !o_full;   // Drop writes when full
  assign do_rd = i_rd_en && !o_empty;  // Drop reads when empty

  assign o_rd_data = mem[rd_ptr[FIFO_AW-1:0]];  // Head entry, fall-through

  // Pointer control
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // Data array
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (do_wr)
      mem[wr_ptr[FIFO_AW-1:0]] <= i_wr_data;
  end

endmodule : byte_fifo

//--- hdl/cipo_deserializer.sv
/*
  Collects CIPO bits into bytes during the RX phase of a frame. Samples on the
  SCK rise strobe, MSB first, and pushes each full byte into the RX FIFO.
*/
module cipo_deserializer
  import spi_solo_pkg::*;
(
  input  logic  i_ext_spi_clk_x,
  input  logic  i_srst,
  spi_cmd_if.rx cmd,
  input  logic  i_rise_stb,
  input  logic  i_cipo,
  // RX FIFO write side
  input  logic  i_rx_full,
  output byte_t o_rx_data,
  output logic  o_rx_push
);

  byte_t rx_shift;  // Bits collected so far
  logic  push_q;
  logic  sample;
  logic  last_bit;

  assign sample   = i_rise_stb && (cmd.state == ST_RX);
  assign last_bit = (cmd.bit_cnt[2:0] == 3'b111);  // Eighth bit of a byte

  ////////////////////////////////////////////////////////////
  // Shift register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (sample)
      rx_shift <= {rx_shift[6:0], i_cipo};  // First bit ends up as MSB
  end

  ////////////////////////////////////////////////////////////
  // Push, one cycle after the last sample
  ////////////////////////////////////////////////////////////
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst)
      push_q <= 1'b0;
    else
      push_q <= sample && last_bit && !i_rx_full;  // Full FIFO loses the byte
  end

  // Bit position comes from the FSM timer, so a new byte restarts by itself
  assign o_rx_data = rx_shift;
  assign o_rx_push = push_q;

endmodule : cipo_deserializer

//--- hdl/cmd_latch.sv
/*
  Accepts a frame command while the bus is idle and holds its lengths until
  the next command. The start reaches the bus FSM as a one-cycle go pulse.
*/
module cmd_latch
  import spi_solo_pkg::*;
(
  input  logic      i_ext_spi_clk_x,
  input  logic      i_srst,
  // Command port
  input  logic      i_go_stand,
  input  tx_len_t   i_tx_len,
  input  wait_cyc_t i_wait_cyc,
  input  rx_len_t   i_rx_len,
  output logic      o_spi_idle,
  // To the bus FSM
  spi_cmd_if.latch  cmd
);

  logic pending;  // Command taken, FSM has not left idle yet
  logic accept;

  // Idle only when nothing is queued and the bus sits in idle
  assign o_spi_idle = !pending && (cmd.state == ST_IDLE);
  assign accept     = i_go_stand && o_spi_idle;  // Busy requests fall through here

  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      pending      <= 1'b0;
      cmd.go       <= 1'b0;
      cmd.tx_len   <= '0;
      cmd.rx_len   <= '0;
      cmd.wait_cyc <= '0;
    end else begin
      cmd.go <= accept;  // Pulse one cycle after acceptance
      if (accept) begin
        pending      <= 1'b1;
        cmd.tx_len   <= i_tx_len;    // Lengths sampled on the accepting cycle
        cmd.rx_len   <= i_rx_len;
        cmd.wait_cyc <= i_wait_cyc;
      end else if (cmd.state != ST_IDLE) begin
        pending <= 1'b0;  // FSM owns the frame now
      end
    end
  end

endmodule : cmd_latch

//--- hdl/sck_phase_gen.sv
/*
  Free-running SCK phase counter. Gives the Mode 0 SCK level and one-cycle
  strobes at the falling and rising points of each SCK period.
*/
module sck_phase_gen
  import spi_solo_pkg::*;
(
  input  logic i_ext_spi_clk_x,
  input  logic i_srst,
  output logic o_sck_level,  // High in the upper half of the period
  output logic o_fall_stb,   // Phase 0, bus updates here
  output logic o_rise_stb    // Mid period, CIPO sampled here
);

  localparam sck_phase_t PH_LAST = sck_phase_t'(SCK_RATIO - 1);
  localparam sck_phase_t PH_HALF = sck_phase_t'(SCK_RATIO / 2);

  sck_phase_t phase;

  ////////////////////////////////////////////////////////////
  // Modulo SCK_RATIO counter
  ////////////////////////////////////////////////////////////
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst)
      phase <= '0;
    else if (phase == PH_LAST)
      phase <= '0;  // Wrap to start of next SCK period
    else
      phase <= phase + 1'b1;
  end

  // Decodes of the counter
  assign o_fall_stb  = (phase == '0);
  assign o_rise_stb  = (phase == PH_HALF);
  assign o_sck_level = (phase >= PH_HALF);  // Low first half, as Mode 0 idles low

endmodule : sck_phase_gen

//--- hdl/spi_bus_fsm.sv
/*
  Frame FSM of the SPI master. Steps through the guard, TX, wait, RX and stop
  phases on SCK fall strobes, drives chip select, gates SCK and serializes
  TX FIFO bytes MSB first on COPI.
*/
module spi_bus_fsm
  import spi_solo_pkg::*;
(
  input  logic  i_ext_spi_clk_x,
  input  logic  i_srst,
  spi_cmd_if.fsm cmd,
  // SCK timing
  input  logic  i_fall_stb,
  input  logic  i_sck_level,
  // TX FIFO read side
  input  byte_t i_tx_data,
  input  logic  i_tx_empty,
  output logic  o_tx_pop,
  // SPI bus
  output logic  o_sck,
  output logic  o_csn,
  output logic  o_copi
);

  spi_state_t state;
  spi_state_t nxt_state;
  spi_state_t after_tx;    // First phase following TX
  spi_state_t after_wait;  // First phase following WAIT
  bit_timer_t bit_cnt;
  bit_timer_t phase_last;  // Final bit-time of the current phase
  logic       phase_done;
  logic       go_seen;     // Go pulse held until the next fall strobe
  logic       byte_start;
  logic       sck_run;
  logic       sck_q;
  logic       csn_q;
  logic       copi_q;
  byte_t      tx_byte;
  byte_t      tx_shift;    // Remaining bits of the byte on COPI

  ////////////////////////////////////////////////////////////
  // Phase lengths and next state
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (state)
      ST_TX:   phase_last = bit_timer_t'({cmd.tx_len, 3'b000}) - 1'b1;
      ST_WAIT: phase_last = bit_timer_t'(cmd.wait_cyc) - 1'b1;
      ST_RX:   phase_last = bit_timer_t'({cmd.rx_len, 3'b000}) - 1'b1;
      default: phase_last = bit_timer_t'(T_GUARD - 1);  // Guard phases
    endcase
  end

  assign phase_done = (bit_cnt == phase_last);

  // Empty phases are skipped
  assign after_wait = (cmd.rx_len != '0) ? ST_RX : ST_STOP_S;
  assign after_tx   = (cmd.wait_cyc != '0) ? ST_WAIT : after_wait;

  always_comb begin
    nxt_state = state;
    case (state)
      ST_IDLE:    if (go_seen || cmd.go) nxt_state = ST_START_D;
      ST_START_D: if (phase_done) nxt_state = ST_START_S;
      ST_START_S: if (phase_done) nxt_state = (cmd.tx_len != '0) ? ST_TX : after_tx;
      ST_TX:      if (phase_done) nxt_state = after_tx;
      ST_WAIT:    if (phase_done) nxt_state = after_wait;
      ST_RX:      if (phase_done) nxt_state = ST_STOP_S;
      ST_STOP_S:  if (phase_done) nxt_state = ST_STOP_D;
      ST_STOP_D:  if (phase_done) nxt_state = ST_IDLE;
      default:    nxt_state = ST_IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // TX byte fetch
  ////////////////////////////////////////////////////////////
  // A new byte starts on entering TX and after every eighth bit
  assign byte_start = (nxt_state == ST_TX) &&
                      ((state != ST_TX) || (bit_cnt[2:0] == 3'b111));
  assign tx_byte    = i_tx_empty ? '0 : i_tx_data;  // Underflow sends zeros
  assign o_tx_pop   = i_fall_stb && byte_start && !i_tx_empty;

  assign sck_run = (state == ST_TX) || (state == ST_WAIT) || (state == ST_RX);

  ////////////////////////////////////////////////////////////
  // State, timer and bus registers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      state   <= ST_IDLE;
      bit_cnt <= '0;
      go_seen <= 1'b0;
      sck_q   <= 1'b0;
      csn_q   <= 1'b1;
      copi_q  <= 1'b0;
    end else begin
      sck_q <= sck_run && i_sck_level;  // Registered so the pin is glitch free
      if (cmd.go)
        go_seen <= 1'b1;
      else if (state != ST_IDLE)
        go_seen <= 1'b0;

      if (i_fall_stb) begin
        state <= nxt_state;
        if ((nxt_state != state) || (state == ST_IDLE))
          bit_cnt <= '0;  // Timer restarts with every phase
        else
          bit_cnt <= bit_cnt + 1'b1;

        // Chip select low from START_S through STOP_S
        csn_q <= !((nxt_state == ST_START_S) || (nxt_state == ST_TX) ||
                   (nxt_state == ST_WAIT) || (nxt_state == ST_RX) ||
                   (nxt_state == ST_STOP_S));

        if (byte_start)
          copi_q <= tx_byte[7];  // MSB leads
        else if (nxt_state == ST_TX)
          copi_q <= tx_shift[7];
        else
          copi_q <= 1'b0;  // COPI parked low outside TX
      end
    end
  end

  // Shifter holds payload only
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_fall_stb) begin
      if (byte_start)
        tx_shift <= {tx_byte[6:0], 1'b0};
      else
        tx_shift <= {tx_shift[6:0], 1'b0};
    end
  end

  assign cmd.state   = state;
  assign cmd.bit_cnt = bit_cnt;

  assign o_sck  = sck_q;
  assign o_csn  = csn_q;
  assign o_copi = copi_q;

endmodule : spi_bus_fsm

//--- hdl/spi_cmd_if.sv
/*
  Command bundle between the command latch, the bus FSM and the CIPO
  deserializer. Carries the frame lengths, the start pulse and the bus status.
*/
interface spi_cmd_if
  import spi_solo_pkg::*;
();

  logic       go;        // One-cycle start pulse
  tx_len_t    tx_len;    // Held for the whole frame
  rx_len_t    rx_len;
  wait_cyc_t  wait_cyc;
  spi_state_t state;     // Current bus phase
  bit_timer_t bit_cnt;   // Bit-time within the current phase

  // Command source, watches the state to know when the bus is free
  modport latch (output go, tx_len, rx_len, wait_cyc, input state);

  modport fsm (input go, tx_len, rx_len, wait_cyc, output state, bit_cnt);

  // RX side only needs to know where the bus is
  modport rx (input state, bit_cnt);

endinterface : spi_cmd_if

//--- hdl/spi_solo.sv
/*
  Top level of the Mode 0 SPI master for one peripheral. TX bytes enter a
  FIFO, a go command runs one chip select frame, RX bytes come out of a
  fall-through FIFO.
*/
module spi_solo
  import spi_solo_pkg::*;
(
  input  logic      i_ext_spi_clk_x,
  input  logic      i_srst,
  // Frame command
  input  logic      i_go_stand,
  input  tx_len_t   i_tx_len,
  input  wait_cyc_t i_wait_cyc,
  input  rx_len_t   i_rx_len,
  output logic      o_spi_idle,
  // TX FIFO write port
  input  byte_t     i_tx_data,
  input  logic      i_tx_enqueue,
  output logic      o_tx_ready,
  // RX FIFO read port
  output byte_t     o_rx_data,
  output logic      o_rx_valid,
  input  logic      i_rx_dequeue,
  // SPI bus
  output logic      o_sck,
  output logic      o_csn,
  output logic      o_copi,
  input  logic      i_cipo
);

  byte_t tx_head;
  logic  tx_empty;
  logic  tx_full;
  logic  tx_pop;
  byte_t rx_byte;
  logic  rx_push;
  logic  rx_full;
  logic  rx_empty;
  logic  sck_level;
  logic  fall_stb;
  logic  rise_stb;

  spi_cmd_if cmd_if ();

  assign o_tx_ready = !tx_full;
  assign o_rx_valid = !rx_empty;

  cmd_latch u_cmd_latch (
    .i_ext_spi_clk_x, .i_srst, .i_go_stand, .i_tx_len, .i_wait_cyc, .i_rx_len,
    .o_spi_idle, .cmd (cmd_if.latch)
  );

  sck_phase_gen u_sck_gen (
    .i_ext_spi_clk_x, .i_srst,
    .o_sck_level (sck_level), .o_fall_stb (fall_stb), .o_rise_stb (rise_stb)
  );

  spi_bus_fsm u_bus_fsm (
    .i_ext_spi_clk_x, .i_srst, .cmd (cmd_if.fsm),
    .i_fall_stb (fall_stb), .i_sck_level (sck_level),
    .i_tx_data (tx_head), .i_tx_empty (tx_empty), .o_tx_pop (tx_pop),
    .o_sck, .o_csn, .o_copi
  );

  cipo_deserializer u_cipo_deser (
    .i_ext_spi_clk_x, .i_srst, .cmd (cmd_if.rx), .i_rise_stb (rise_stb),
    .i_cipo, .i_rx_full (rx_full), .o_rx_data (rx_byte), .o_rx_push (rx_push)
  );

  // User writes, FSM reads
  byte_fifo u_tx_fifo (
    .i_ext_spi_clk_x, .i_srst,
    .i_wr_data (i_tx_data), .i_wr_en (i_tx_enqueue), .o_full (tx_full),
    .o_rd_data (tx_head), .i_rd_en (tx_pop), .o_empty (tx_empty)
  );

  // Deserializer writes, user reads
  byte_fifo u_rx_fifo (
    .i_ext_spi_clk_x, .i_srst,
    .i_wr_data (rx_byte), .i_wr_en (rx_push), .o_full (rx_full),
    .o_rd_data (o_rx_data), .i_rd_en (i_rx_dequeue), .o_empty (rx_empty)
  );

endmodule : spi_solo

//--- hdl/spi_solo_pkg.sv
/*
  Shared constants, width types and the bus state encoding of the SPI master.
  Every RTL module of the design imports this package.
*/
package spi_solo_pkg;

  ////////////////////////////////////////////////////////////
  // Timing and sizing constants
  ////////////////////////////////////////////////////////////
  localparam int SCK_RATIO  = 8;   // System clocks per SCK period, even
  localparam int T_GUARD    = 4;   // Bit-times in each chip select guard phase
  localparam int FIFO_DEPTH = 16;  // Entries in the TX and in the RX FIFO

  localparam int FIFO_AW  = $clog2(FIFO_DEPTH);  // FIFO address bits
  localparam int SCK_PH_W = $clog2(SCK_RATIO);   // Phase counter bits

  ////////////////////////////////////////////////////////////
  // Width types
  ////////////////////////////////////////////////////////////
  typedef logic [3:0] tx_len_t;    // TX byte count of a frame
  typedef logic [3:0] rx_len_t;    // RX byte count of a frame
  typedef logic [1:0] wait_cyc_t;  // Wait bit-times between TX and RX
  typedef logic [7:0] byte_t;      // One data byte on the bus

  // Bit-time counter, large enough for 15 bytes of 8 bits
  typedef logic [6:0] bit_timer_t;

  // One extra bit beyond the address tells full from empty
  typedef logic [FIFO_AW:0] fifo_ptr_t;

  typedef logic [SCK_PH_W-1:0] sck_phase_t;  // Position inside one SCK period

  ////////////////////////////////////////////////////////////
  // Bus FSM states, in frame order
  ////////////////////////////////////////////////////////////
  typedef enum logic [2:0] {
    ST_IDLE,     // Chip select high, waiting for a command
    ST_START_D,  // Guard, chip select still high
    ST_START_S,  // Guard, chip select low
    ST_TX,       // COPI bytes
    ST_WAIT,     // Dummy bit-times
    ST_RX,       // CIPO bytes
    ST_STOP_S,   // Guard, chip select low
    ST_STOP_D    // Guard, chip select high
  } spi_state_t;

endpackage : spi_solo_pkg

//--- spi_solo.f
hdl/spi_solo_pkg.sv
hdl/spi_cmd_if.sv
hdl/byte_fifo.sv
hdl/sck_phase_gen.sv
hdl/cmd_latch.sv
hdl/spi_bus_fsm.sv
hdl/cipo_deserializer.sv
hdl/spi_solo.sv
bench/spi_periph_model.sv
bench/tb_spi_solo.sv
